//--- pn_macros.svh
// PRBS link checker constants
// sample width, buffer depth, sync threshold and generator seed
// shared by the packages and the RTL blocks

`ifndef PN_MACROS_SVH
`define PN_MACROS_SVH

// width of one adc sample word
`define PN_SAMPLE_W 12

// buffer entries, also the credits the generator starts with
`define PN_FIFO_DEPTH 8

// consecutive mismatches to lose sync, consecutive matches to regain it
`define PN_OOS_COUNT 16

// generator lfsr start value, must be nonzero
`define PN_SEED 23'h5a_3c71

`endif

//--- pn_types_pkg.sv
// PRBS data types
// sample and lfsr state words, monitor state encoding and the
// PN23 (x^23 + x^18 + 1) advance used by generator and monitor

`default_nettype none

`include "pn_macros.svh"

package pn_types_pkg;

  // one adc sample word
  typedef logic [`PN_SAMPLE_W-1:0] sample_t;

  // pn23 lfsr state, holds the last 23 sequence bits
  typedef logic [22:0] pn_state_t;

  // monitor predictor source
  typedef enum logic {
    MON_SEEDING,
    MON_TRACKING
  } mon_state_e;

  // one sample worth of shifts, new bit enters at the lsb
  // so the low sample bits of the result are the new sample
  function automatic pn_state_t pn_advance(input pn_state_t state);
    pn_state_t s;
    s = state;
    for (int i = 0; i < `PN_SAMPLE_W; i++) begin
      s = {s[21:0], s[22] ^ s[17]};
    end
    return s;
  endfunction

endpackage

`default_nettype wire

//--- pn_link_pkg.sv
// PRBS link types
// sample beat carried from generator to buffer and from buffer to
// monitor, plus the credit counter type of the generator

`default_nettype none

`include "pn_macros.svh"

package pn_link_pkg;

  import pn_types_pkg::*;

  // one sample on a link, valid marks a real beat
  typedef struct packed {
    logic    valid;
    sample_t sample;
  } sample_beat_t;

  // credits, counts 0 to full buffer depth
  typedef logic [$clog2(`PN_FIFO_DEPTH+1)-1:0] credit_t;

endpackage

`default_nettype wire

//--- pn_sync_core.sv
// PRBS sync decision
// compares each valid received sample with its prediction
// a run of mismatches drops sync, a run of matches restores it
// pn_err pulses once per bad sample while in sync

`timescale 1ns/1ps
`default_nettype none

`include "pn_macros.svh"

module pn_sync_core import pn_types_pkg::*; (
  input  wire     adc_clk,
  input  wire     rst,
  input  wire     sample_valid,
  input  sample_t rx_sample,
  input  sample_t pred_sample,
  output logic    pn_oos,
  output logic    pn_err
);

  localparam int CNT_W = $clog2(`PN_OOS_COUNT);

  logic [CNT_W-1:0] run_cnt;
  logic             match;
  logic             against;
  logic             flip;
  logic             oos_next;

  assign match    = (rx_sample == pred_sample);
  // sample that argues for the other state
  assign against  = sample_valid && (match == pn_oos);
  assign flip     = against && (run_cnt == CNT_W'(`PN_OOS_COUNT - 1));
  assign oos_next = flip ? ~pn_oos : pn_oos;

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      run_cnt <= '0;
      pn_oos  <= 1'b1;
      pn_err  <= 1'b0;
    end else begin
      pn_oos <= oos_next;
      // the mismatch that drops sync is not an error pulse
      pn_err <= sample_valid && !match && !oos_next;
      if (sample_valid) begin
        // run restarts on any agreeing sample or after a flip
        run_cnt <= (against && !flip) ? run_cnt + 1'b1 : '0;
      end
    end
  end

  a_err_in_sync: assert property (
    @(posedge adc_clk) disable iff (rst)
    pn_err |-> !pn_oos
  );

endmodule

`default_nettype wire

//--- pn_rx_monitor.sv
// PRBS receive monitor
// predicts each received sample of the pn23 sequence
// out of sync it seeds the predictor from the last received bits,
// in sync the predictor runs on its own state
// the sync and error decision sits in pn_sync_core

`timescale 1ns/1ps
`default_nettype none

`include "pn_macros.svh"

module pn_rx_monitor import pn_types_pkg::*, pn_link_pkg::*; (
  input  wire          adc_clk,
  input  wire          rst,
  input  sample_beat_t rx_beat,
  output logic         pn_oos,
  output logic         pn_err
);

  logic [2*`PN_SAMPLE_W-1:0] rx_window;
  pn_state_t                 pred_state;
  pn_state_t                 pred_src;
  pn_state_t                 pred_next;
  sample_t                   pred_sample;
  mon_state_e                mon_state;

  // seeding while sync is lost, tracking otherwise
  assign mon_state = pn_oos ? MON_SEEDING : MON_TRACKING;

  // seed from the last 23 received bits, or keep running free
  assign pred_src    = (mon_state == MON_SEEDING) ?
                       rx_window[$bits(pn_state_t)-1:0] : pred_state;
  assign pred_next   = pn_advance(pred_src);
  assign pred_sample = pred_next[`PN_SAMPLE_W-1:0];

  // ********************
  // history and predictor
  // ********************

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      rx_window  <= '0;
      pred_state <= '0;
    end else if (rx_beat.valid) begin
      // newest sample in the low half
      rx_window  <= {rx_window[`PN_SAMPLE_W-1:0], rx_beat.sample};
      pred_state <= pred_next;
    end
  end

  // match counting and flags
  pn_sync_core u_sync_core (
    .adc_clk      (adc_clk),
    .rst          (rst),
    .sample_valid (rx_beat.valid),
    .rx_sample    (rx_beat.sample),
    .pred_sample  (pred_sample),
    .pn_oos       (pn_oos),
    .pn_err       (pn_err)
  );

endmodule

`default_nettype wire

//--- pn_sample_fifo.sv
// PRBS sample buffer
// circular buffer between generator and monitor
// pops whenever it holds data and rx_en is high, rx_beat is registered
// every pop sends one credit back to the generator

`timescale 1ns/1ps
`default_nettype none

`include "pn_macros.svh"

module pn_sample_fifo import pn_types_pkg::*, pn_link_pkg::*; (
  input  wire          adc_clk,
  input  wire          rst,
  input  sample_beat_t gen_beat,
  input  wire          rx_en,
  output sample_beat_t rx_beat,
  output logic         credit_return
);

  localparam int PTR_W = $clog2(`PN_FIFO_DEPTH);

  sample_t            mem [`PN_FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr;
  logic [PTR_W-1:0]   rd_ptr;
  credit_t            fill;
  logic               wr;
  logic               pop;

  // generator only sends with credit, so every valid beat is taken
  assign wr  = gen_beat.valid;
  assign pop = rx_en && (fill != '0);

  // pointer step with wrap at the buffer end
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
    return (p == PTR_W'(`PN_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  // ********************
  // storage
  // ********************

  always_ff @(posedge adc_clk) begin
    if (wr) begin
      mem[wr_ptr] <= gen_beat.sample;
    end
    rx_beat.sample <= mem[rd_ptr];
  end

  // ********************
  // pointers and fill
  // ********************

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill          <= '0;
      rx_beat.valid <= 1'b0;
      credit_return <= 1'b0;
    end else begin
      rx_beat.valid <= pop;
      credit_return <= pop;
      if (wr) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      case ({wr, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
    end
  end

  // credit loop keeps the generator from overrunning the buffer
  a_no_write_full: assert property (
    @(posedge adc_clk) disable iff (rst)
    wr |-> (fill != credit_t'(`PN_FIFO_DEPTH))
  );

  // an empty count leaves the pointers level so a pop never reads an unwritten slot
  a_no_pop_empty: assert property (
    @(posedge adc_clk) disable iff (rst)
    (fill == '0) |-> (rd_ptr == wr_ptr)
  );

endmodule

`default_nettype wire

//--- pn_prbs_gen.sv
// PRBS sample generator
// emits the next sample of the pn23 sequence for each credit it holds,
// one beat per cycle at most
// err_inject flips bit 0 of the sample sent in that cycle, the lfsr
// itself keeps running clean

`timescale 1ns/1ps
`default_nettype none

`include "pn_macros.svh"

module pn_prbs_gen import pn_types_pkg::*, pn_link_pkg::*; (
  input  wire          adc_clk,
  input  wire          rst,
  input  wire          gen_en,
  input  wire          err_inject,
  input  wire          credit_return,
  output sample_beat_t gen_beat
);

  pn_state_t lfsr;
  pn_state_t lfsr_next;
  credit_t   credit_cnt;
  logic      send;

  // ********************
  // send decision
  // ********************

  // a beat needs a free slot downstream
  assign send      = gen_en && (credit_cnt != '0);
  assign lfsr_next = pn_advance(lfsr);

  always_ff @(posedge adc_clk) begin
    if (rst) begin
      lfsr           <= `PN_SEED;
      credit_cnt     <= credit_t'(`PN_FIFO_DEPTH);
      gen_beat.valid <= 1'b0;
    end else begin
      gen_beat.valid <= send;
      // lfsr holds while no credit so the sequence stays unbroken
      if (send) begin
        lfsr <= lfsr_next;
      end
      // one credit out per beat, one back per pop
      case ({send, credit_return})
        2'b10:   credit_cnt <= credit_cnt - 1'b1;
        2'b01:   credit_cnt <= credit_cnt + 1'b1;
        default: credit_cnt <= credit_cnt;
      endcase
    end
    // payload is only looked at with valid
    gen_beat.sample <= lfsr_next[`PN_SAMPLE_W-1:0] ^ sample_t'(err_inject);
  end

  // ********************
  // checks
  // ********************

  // a send at zero credit or a stray return would push the count past the depth
  a_credit_in_range: assert property (
    @(posedge adc_clk) disable iff (rst)
    credit_cnt <= credit_t'(`PN_FIFO_DEPTH)
  );

endmodule

`default_nettype wire

//--- pn_link_top.sv
// PRBS link top
// generator feeds the sample buffer under credit flow control,
// the buffer feeds the receive monitor while rx_en is high

`timescale 1ns/1ps
`default_nettype none

module pn_link_top import pn_link_pkg::*; (
  input  wire          adc_clk,
  input  wire          rst,
  input  wire          gen_en,
  input  wire          rx_en,
  input  wire          err_inject,
  output sample_beat_t rx_beat,
  output logic         pn_oos,
  output logic         pn_err
);

  sample_beat_t gen_beat;
  logic         credit_return;

  // producer
  pn_prbs_gen u_gen (
    .adc_clk       (adc_clk),
    .rst           (rst),
    .gen_en        (gen_en),
    .err_inject    (err_inject),
    .credit_return (credit_return),
    .gen_beat      (gen_beat)
  );

  // buffer, pops model the receiver
  pn_sample_fifo u_fifo (
    .adc_clk       (adc_clk),
    .rst           (rst),
    .gen_beat      (gen_beat),
    .rx_en         (rx_en),
    .rx_beat       (rx_beat),
    .credit_return (credit_return)
  );

  // checker
  pn_rx_monitor u_mon (
    .adc_clk (adc_clk),
    .rst     (rst),
    .rx_beat (rx_beat),
    .pn_oos  (pn_oos),
    .pn_err  (pn_err)
  );

endmodule

`default_nettype wire

//--- tb_pn_link.sv
// PRBS link testbench
// runs reset, lock, error injection, back-pressure and loss of sync
// through the generator, buffer and monitor chain
// every received sample is checked against a local pn23 model

`timescale 1ns/1ps
`default_nettype none

`include "pn_macros.svh"

module tb_pn_link import pn_types_pkg::*, pn_link_pkg::*; ();

  localparam int OOS = `PN_OOS_COUNT;
  // beats per test: lock, single error, stall, random stalls, loss
  localparam int TEST_BEATS  = 60 + 40 + 40 + 200 + 60;
  // four cycles of 4 ns per beat, drains and settling in the margin
  localparam int WATCHDOG_NS = (TEST_BEATS * 4 + 400) * 4;

  logic         adc_clk;
  logic         rst;
  logic         gen_en;
  logic         rx_en;
  logic         err_inject;
  sample_beat_t rx_beat;
  logic         pn_oos;
  logic         pn_err;

  // model state and per-test bookkeeping
  pn_state_t model;
  string     cur_test;
  logic      oos_prev;
  int        errors;
  int        checks;
  int        test_errors;
  int        beats;
  int        inject_left;
  int        err_pulses;
  int        oos_rises;
  int        lock_beat;

  pn_link_top uut (
    .adc_clk    (adc_clk),
    .rst        (rst),
    .gen_en     (gen_en),
    .rx_en      (rx_en),
    .err_inject (err_inject),
    .rx_beat    (rx_beat),
    .pn_oos     (pn_oos),
    .pn_err     (pn_err)
  );

  initial begin
    adc_clk = 1'b0;
    forever #2 adc_clk = ~adc_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, tests did not finish within %0d ns", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

  // x^23 + x^18 + 1, twelve new bits per sample, newest at the lsb
  function automatic pn_state_t prbs_step(input pn_state_t s);
    pn_state_t r;
    r = s;
    repeat (`PN_SAMPLE_W) begin
      r = {r[21:0], r[22] ^ r[17]};
    end
    return r;
  endfunction

  // ********************
  // compare tasks
  // ********************

  task automatic note_fail(input string msg);
    errors++;
    test_errors++;
    $display("%s", msg);
  endtask

  task automatic check_sample(input string what, input sample_t expd, input sample_t got);
    checks++;
    if (got !== expd)
      note_fail($sformatf("[FAIL] %s %s: expected %h actual %h", cur_test, what, expd, got));
  endtask

  task automatic check_flag(input string what, input logic expd, input logic got);
    checks++;
    if (got !== expd)
      note_fail($sformatf("[FAIL] %s %s: expected %b actual %b", cur_test, what, expd, got));
  endtask

  task automatic check_count(input string what, input int expd, input int got);
    checks++;
    if (got != expd)
      note_fail($sformatf("[FAIL] %s %s: expected %0d actual %0d", cur_test, what, expd, got));
  endtask

  // one cycle, flags first since they trail their beat by a cycle
  task automatic tick();
    sample_t expd;
    @(posedge adc_clk);
    #1;
    if (pn_err) err_pulses++;
    if (pn_oos && !oos_prev) oos_rises++;
    if (!pn_oos && oos_prev) lock_beat = beats;
    oos_prev = pn_oos;
    if (rx_beat.valid) begin
      model = prbs_step(model);
      expd  = model[`PN_SAMPLE_W-1:0];
      // an injected sample differs in bit 0 only
      if (inject_left > 0 && rx_beat.sample[0] != expd[0]) begin
        expd[0] = ~expd[0];
        inject_left--;
      end
      check_sample("rx sample", expd, rx_beat.sample);
      beats++;
    end
  endtask

  // generator off, buffer empties, idle once nothing arrives for 4 cycles
  task automatic drain();
    int idle;
    int n;
    idle       = 0;
    n          = 0;
    gen_en     = 1'b0;
    err_inject = 1'b0;
    rx_en      = 1'b1;
    while (idle < 4 && n < 32) begin
      tick();
      idle = rx_beat.valid ? 0 : idle + 1;
      n++;
    end
    if (idle < 4) note_fail($sformatf("%s: buffer did not empty", cur_test));
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    test_errors = 0;
    beats       = 0;
    inject_left = 0;
    err_pulses  = 0;
    oos_rises   = 0;
    lock_beat   = -1;
  endtask

  task automatic end_test();
    if (test_errors == 0) $display("test %s: ok", cur_test);
    else $display("test %s: %0d errors", cur_test, test_errors);
  endtask

  // ********************
  // directed tests
  // ********************

  task automatic test_reset();
    start_test("reset");
    repeat (2) tick();
    check_flag("pn_oos", 1'b1, pn_oos);
    check_flag("pn_err", 1'b0, pn_err);
    check_flag("rx valid", 1'b0, rx_beat.valid);
    end_test();
  endtask

  task automatic test_lock();
    start_test("lock");
    gen_en = 1'b1;
    rx_en  = 1'b1;
    repeat (60) tick();
    if (lock_beat < 0 || lock_beat > OOS + 2)
      note_fail($sformatf("%s: pn_oos did not fall within %0d beats", cur_test, OOS + 2));
    check_count("oos rises", 0, oos_rises);
    check_count("err pulses", 0, err_pulses);
    drain();
    check_flag("pn_oos", 1'b0, pn_oos);
    end_test();
  endtask

  task automatic test_single_error();
    start_test("single_error");
    gen_en = 1'b1;
    repeat (10) tick();
    err_inject  = 1'b1;
    inject_left = 1;
    tick();
    err_inject = 1'b0;
    repeat (29) tick();
    drain();
    check_count("injected samples missing", 0, inject_left);
    check_count("err pulses", 1, err_pulses);
    check_count("oos rises", 0, oos_rises);
    end_test();
  endtask

  task automatic test_backpressure();
    start_test("backpressure");
    gen_en = 1'b1;
    rx_en  = 1'b0;
    repeat (40) tick();
    check_count("beats during stall", 0, beats);
    drain();
    check_count("buffered beats", `PN_FIFO_DEPTH, beats);
    gen_en = 1'b1;
    repeat (200) begin
      rx_en = ($urandom % 4) != 0;
      tick();
    end
    drain();
    check_count("err pulses", 0, err_pulses);
    check_count("oos rises", 0, oos_rises);
    end_test();
  endtask

  task automatic test_loss_relock();
    int release_beat;
    int n;
    start_test("loss_relock");
    gen_en = 1'b1;
    repeat (8) tick();
    err_inject  = 1'b1;
    inject_left = OOS;
    repeat (OOS) tick();
    err_inject = 1'b0;
    // wait for the last corrupted sample to come through
    n = 0;
    while (inject_left > 0 && n < 16) begin
      tick();
      n++;
    end
    check_count("injected samples missing", 0, inject_left);
    release_beat = beats;
    repeat (36) tick();
    check_count("oos rises", 1, oos_rises);
    if (lock_beat < 0 || lock_beat - release_beat > OOS + 2)
      note_fail($sformatf("%s: no relock within %0d beats", cur_test, OOS + 2));
    drain();
    check_flag("pn_oos", 1'b0, pn_oos);
    end_test();
  endtask

  initial begin
    void'($urandom(32'hc4af_919d));
    rst        = 1'b1;
    gen_en     = 1'b0;
    rx_en      = 1'b0;
    err_inject = 1'b0;
    model      = `PN_SEED;
    oos_prev   = 1'b1;
    errors     = 0;
    checks     = 0;
    repeat (4) @(posedge adc_clk);
    #1;
    rst = 1'b0;
    test_reset();
    test_lock();
    test_single_error();
    test_backpressure();
    test_loss_relock();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- pn_link.f
+incdir+.
pn_types_pkg.sv
pn_link_pkg.sv
pn_sync_core.sv
pn_rx_monitor.sv
pn_sample_fifo.sv
pn_prbs_gen.sv
pn_link_top.sv
tb_pn_link.sv

//--- run_sim.sh
#!/bin/sh
# build and run the PRBS link testbench with Verilator
# the run passes only if the simulation log holds the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_pn_link \
  -f pn_link.f -o tb_pn_link > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_pn_link > sim.log 2>&1
cat sim.log
grep -qx "Done: no errors" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
